//--- compile.f
+incdir+source
source/dx_pkg.sv
source/dx_decode_if.sv
source/rv_decoder.sv
source/hazard_unit.sv
source/id_ex_reg.sv
source/exec_unit.sv
source/decode_execute_top.sv
verif/tb_decode_execute.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/100ps
TOP       = tb_decode_execute
FILELIST  = compile.f
OBJDIR    = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- verif/tb_decode_execute.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module tb_decode_execute;
    import dx_pkg::*;

    typedef logic [`DX_XLEN-1:0] xlen_t;

    typedef struct packed {
        dx_ctrl_t              c;      // only fields seen at the ports
        logic [`DX_REG_AW-1:0] rd;
        xlen_t                 alu;
        xlen_t                 sdata;
        logic                  redir;
        xlen_t                 rpc;
    } exp_t;

    logic                  clk;
    logic                  rst_n_i;
    logic [31:0]           instr_i;
    xlen_t                 pc_i;
    xlen_t                 rs1_data_i;
    xlen_t                 rs2_data_i;
    logic                  mem_stall_i;
    logic                  stall_o;
    xlen_t                 alu_result_o;
    logic [`DX_REG_AW-1:0] rd_addr_o;
    logic                  rd_we_o;
    logic                  mem_read_o;
    logic                  mem_write_o;
    logic [`DX_MASK_W-1:0] mem_mask_o;
    logic                  load_sext_o;
    xlen_t                 store_data_o;
    logic                  redirect_o;
    xlen_t                 redirect_pc_o;

    logic [31:0] row_instr [64];
    xlen_t       row_pc    [64];
    xlen_t       row_a     [64];
    xlen_t       row_b     [64];
    int          row_stall [64]; // mem stall cycles before the row is taken
    exp_t        row_exp   [64];
    int          n_rows;
    int          mismatch_cnt;
    int          other_cnt;
    bit          table_ready;

    decode_execute_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [`DX_MASK_W-1:0] mask_for(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return 8'h01;
            2'b01:   return 8'h03;
            2'b10:   return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input logic w,
                                      input xlen_t a, input xlen_t b);
        xlen_t       r;
        logic [31:0] lo;
        int          sh;
        sh = w ? int'(b[4:0]) : int'(b[5:0]);
        lo = a[31:0];
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            3'b010:  r = {{(`DX_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b011:  r = {{(`DX_XLEN-1){1'b0}}, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (w && alt) begin
                    lo = $signed(lo) >>> sh;
                    r  = {32'b0, lo};
                end else if (w) begin
                    r = {32'b0, lo >> sh};
                end else if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        if (w) begin
            r = {{32{r[31]}}, r[31:0]}; // w forms keep a sign-extended low word
        end
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // {uses rs1, uses rs2}
    function automatic logic [1:0] model_uses(input logic [31:0] ins);
        case (ins[6:0])
            7'h37, 7'h17, 7'h6f:        return 2'b00;
            7'h33, 7'h3b, 7'h23, 7'h63: return 2'b11;
            default:                    return 2'b10;
        endcase
    endfunction

    function automatic exp_t model_exec(input logic [31:0] ins, input xlen_t pc,
                                        input xlen_t a, input xlen_t b);
        exp_t       e;
        logic [2:0] f3;
        logic       wr;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      imm_b;
        xlen_t      imm_u;
        xlen_t      imm_j;
        e     = '0;
        wr    = 1'b1;
        f3    = ins[14:12];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
        imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        case (ins[6:0])
            7'h33, 7'h3b: e.alu = alu_ref(f3, ins[30], ins[6:0] == 7'h3b, a, b);
            7'h13, 7'h1b: e.alu = alu_ref(f3, ins[30] && (f3 == 3'b101), ins[6:0] == 7'h1b,
                                          a, imm_i);
            7'h03: begin
                e.alu         = a + imm_i;
                e.c.mem_read  = 1'b1;
                e.c.mem_mask  = mask_for(f3);
                e.c.load_sext = !f3[2];
            end
            7'h23: begin
                e.alu         = a + imm_s;
                e.c.mem_write = 1'b1;
                e.c.mem_mask  = mask_for(f3);
                e.sdata       = b;
                wr            = 1'b0;
            end
            7'h63: begin
                e.redir = branch_taken(f3, a, b);
                e.rpc   = pc + imm_b;
                wr      = 1'b0;
            end
            7'h6f: begin
                e.alu   = pc + `DX_XLEN'd4;
                e.redir = 1'b1;
                e.rpc   = pc + imm_j;
            end
            7'h67: begin
                e.alu   = pc + `DX_XLEN'd4;
                e.redir = 1'b1;
                e.rpc   = (a + imm_i) & ~`DX_XLEN'd1;
            end
            7'h37:   e.alu = imm_u;
            7'h17:   e.alu = pc + imm_u;
            default: wr = 1'b0;
        endcase
        e.c.wb_en = wr && (ins[11:7] != 5'd0);
        e.rd      = e.c.wb_en ? ins[11:7] : '0;
        return e;
    endfunction

    task automatic add_row(input logic [31:0] ins, input xlen_t a, input xlen_t b,
                           input int stall);
        row_instr[n_rows] = ins;
        row_pc[n_rows]    = 64'h8000_0000 + (xlen_t'(n_rows) << 2);
        row_a[n_rows]     = a;
        row_b[n_rows]     = b;
        row_stall[n_rows] = stall;
        row_exp[n_rows]   = model_exec(ins, row_pc[n_rows], a, b);
        n_rows++;
    endtask

    task automatic add_rand(input logic [31:0] ins);
        add_row(ins, rnd64(), rnd64(), 0);
    endtask

    task automatic fill_table();
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));   // add
        add_rand(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));   // sub
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, 7'h33));   // sll
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, 7'h33));   // slt
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3, 7'h33));   // sltu
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3, 7'h33), rnd64(), rnd64(), 2); // xor
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, 7'h33));   // srl
        add_rand(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, 7'h33));   // sra
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3, 7'h33));   // or
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, 7'h33));   // and
        add_rand(enc_i(12'hffb, 5'd1, 3'b000, 5'd4, 7'h13));       // addi -5
        add_rand(enc_i(12'd37, 5'd1, 3'b001, 5'd4, 7'h13));        // slli 37
        add_rand(enc_i(12'h40d, 5'd1, 3'b101, 5'd4, 7'h13));       // srai 13
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h3b));   // addw
        add_rand(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, 7'h3b));   // sraw
        add_rand(enc_i(12'hfff, 5'd1, 3'b000, 5'd4, 7'h1b));       // addiw -1
        add_rand({20'h12345, 5'd7, 7'h37});                        // lui
        add_rand({20'h80000, 5'd8, 7'h17});                        // auipc
        add_row(enc_i(12'd8, 5'd1, 3'b011, 5'd5, 7'h03), 64'h1000, '0, 0);  // ld
        add_row(enc_i(12'hfff, 5'd1, 3'b100, 5'd6, 7'h03), 64'h1000, '0, 0); // lbu
        add_row(32'h0020_b823, 64'h2000, rnd64(), 0);              // sd x2, 16(x1)
        add_row(32'h0020_a823, 64'h2000, rnd64(), 0);              // sw x2, 16(x1)
        add_row(32'h0020_9323, 64'h2000, rnd64(), 0);              // sh x2, 6(x1)
        // load-use pairs, the last one through x0
        add_row(enc_i(12'd0, 5'd1, 3'b011, 5'd5, 7'h03), 64'h3000, '0, 0);
        add_rand(enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd9, 7'h33));
        add_row(enc_i(12'd8, 5'd1, 3'b011, 5'd6, 7'h03), 64'h3000, '0, 0);
        add_rand(enc_r(7'h00, 5'd6, 5'd1, 3'b110, 5'd10, 7'h33));
        add_row(enc_i(12'd0, 5'd1, 3'b010, 5'd0, 7'h03), 64'h3000, '0, 0);
        add_rand(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd9, 7'h33));
        add_row(32'h0020_8463, 64'h1234, 64'h1234, 0);             // beq taken
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));   // dropped
        add_row(32'h0020_9463, 64'h1234, 64'h1234, 0);             // bne not taken
        add_row(32'h0020_c463, 64'hffff_ffff_ffff_fffb, 64'd3, 0); // blt taken
        add_rand(enc_i(12'd1, 5'd1, 3'b000, 5'd4, 7'h13));         // dropped
        add_row(32'h0020_f463, 64'd1, '1, 0);                      // bgeu not taken
        add_row(32'h0100_00ef, '0, '0, 0);                         // jal x1, 16
        add_rand(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));   // dropped
        add_row(enc_i(12'd4, 5'd6, 3'b000, 5'd1, 7'h67), 64'h8000_1003, '0, 0); // jalr
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3, 7'h33), rnd64(), rnd64(), 1);
        add_rand(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33));
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endtask

    task automatic check_ctrl(input string name, input dx_ctrl_t got, input dx_ctrl_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input logic [`DX_REG_AW-1:0] got,
                             input logic [`DX_REG_AW-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        dx_ctrl_t got_c;
        got_c           = '0;
        got_c.wb_en     = rd_we_o;
        got_c.mem_read  = mem_read_o;
        got_c.mem_write = mem_write_o;
        got_c.mem_mask  = mem_mask_o;
        got_c.load_sext = load_sext_o;
        check_ctrl("rd_we_o/mem_read_o/mem_write_o/mem_mask_o/load_sext_o", got_c, e.c);
        check_reg("rd_addr_o", rd_addr_o, e.rd);
        check_bit("redirect_o", redirect_o, e.redir);
        if (e.c.wb_en || e.c.mem_read || e.c.mem_write) begin
            check_data("alu_result_o", alu_result_o, e.alu);
        end
        if (e.c.mem_write) begin
            check_data("store_data_o", store_data_o, e.sdata);
        end
        if (e.redir) begin
            check_data("redirect_pc_o", redirect_pc_o, e.rpc);
        end
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((n_rows * 4 + 40) * 4);
        other_cnt++;
        $display("timeout: run did not finish within %0d cycles", n_rows * 4 + 40);
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : run
        int          row_idx;
        int          stall_left;
        logic [1:0]  uses;
        logic        load_use;
        logic [31:0] ins;
        exp_t        cur;
        rst_n_i      = 1'b0;
        instr_i      = `DX_NOP_INSTR;
        pc_i         = '0;
        rs1_data_i   = '0;
        rs2_data_i   = '0;
        mem_stall_i  = 1'b0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        n_rows       = 0;
        void'($urandom(32'hcf5e_fe18));
        fill_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n_i = 1'b1;
        #1.5;
        check_bit("stall_o", stall_o, 1'b0); // stage holds the reset nop
        compare_outputs('0);
        cur        = '0;
        row_idx    = 0;
        stall_left = row_stall[0];
        while (row_idx < n_rows) begin
            @(posedge clk);
            #0.5;
            ins         = row_instr[row_idx];
            instr_i     = ins;
            pc_i        = row_pc[row_idx];
            rs1_data_i  = row_a[row_idx];
            rs2_data_i  = row_b[row_idx];
            mem_stall_i = (stall_left > 0);
            #1.5;
            uses     = model_uses(ins);
            load_use = cur.c.mem_read && (cur.rd != '0) &&
                       ((uses[1] && ins[19:15] == cur.rd) || (uses[0] && ins[24:20] == cur.rd));
            check_bit("stall_o", stall_o, mem_stall_i || load_use);
            compare_outputs(cur);
            if (mem_stall_i) begin
                stall_left--;    // stage holds, row offered again
            end else if (load_use) begin
                cur = '0;        // bubble, row offered again
            end else begin
                cur = cur.redir ? '0 : row_exp[row_idx];
                row_idx++;
                if (row_idx < n_rows) begin
                    stall_left = row_stall[row_idx];
                end
            end
        end
        @(posedge clk);
        #0.5;
        instr_i     = `DX_NOP_INSTR;
        mem_stall_i = 1'b0;
        #1.5;
        compare_outputs(cur);
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- source/decode_execute_top.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module decode_execute_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [31:0]            instr_i,
    input  logic [`DX_XLEN-1:0]    pc_i,
    input  logic [`DX_XLEN-1:0]    rs1_data_i,
    input  logic [`DX_XLEN-1:0]    rs2_data_i,
    input  logic                   mem_stall_i,
    output logic                   stall_o,
    output logic [`DX_XLEN-1:0]    alu_result_o,
    output logic [`DX_REG_AW-1:0]  rd_addr_o,
    output logic                   rd_we_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic [`DX_MASK_W-1:0]  mem_mask_o,
    output logic                   load_sext_o,
    output logic [`DX_XLEN-1:0]    store_data_o,
    output logic                   redirect_o,
    output logic [`DX_XLEN-1:0]    redirect_pc_o
);
    import dx_pkg::*;

    dx_payload_t ex_payload;
    logic        flush;
    logic        hold;

    dx_decode_if dec_if ();

    rv_decoder u_decoder (
        .instr_i (instr_i),
        .dec     (dec_if)
    );

    hazard_unit u_hazard (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dec          (dec_if),
        .ex_payload_i (ex_payload),
        .redirect_i   (redirect_o),
        .mem_stall_i  (mem_stall_i),
        .flush_o      (flush),
        .hold_o       (hold),
        .stall_o      (stall_o)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .hold_i       (hold),
        .dec          (dec_if),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .ex_payload_o (ex_payload)
    );

    exec_unit u_exec (
        .ex_payload_i  (ex_payload),
        .alu_result_o  (alu_result_o),
        .rd_addr_o     (rd_addr_o),
        .rd_we_o       (rd_we_o),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_mask_o    (mem_mask_o),
        .load_sext_o   (load_sext_o),
        .store_data_o  (store_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

//--- source/exec_unit.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module exec_unit (
    input  dx_pkg::dx_payload_t    ex_payload_i,
    output logic [`DX_XLEN-1:0]    alu_result_o,
    output logic [`DX_REG_AW-1:0]  rd_addr_o,
    output logic                   rd_we_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic [`DX_MASK_W-1:0]  mem_mask_o,
    output logic                   load_sext_o,
    output logic [`DX_XLEN-1:0]    store_data_o,
    output logic                   redirect_o,
    output logic [`DX_XLEN-1:0]    redirect_pc_o
);
    import dx_pkg::*;

    dx_ctrl_t            ctrl;
    logic [`DX_XLEN-1:0] rs1_v;
    logic [`DX_XLEN-1:0] rs2_v;
    logic [`DX_XLEN-1:0] op_a;
    logic [`DX_XLEN-1:0] op_b;
    logic [`DX_XLEN-1:0] a_ext;   // op_a widened for w forms
    logic [5:0]          shamt;
    logic [`DX_XLEN-1:0] res;
    logic                taken;

    assign ctrl  = ex_payload_i.ctrl;
    assign rs1_v = ex_payload_i.rs1_data;
    assign rs2_v = ex_payload_i.rs2_data;

    always_comb begin
        case (ctrl.sel_a)
            OPA_PC:   op_a = ex_payload_i.pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = rs1_v;
        endcase
        case (ctrl.sel_b)
            OPB_IMM:  op_b = ex_payload_i.imm;
            OPB_FOUR: op_b = `DX_XLEN'd4;
            default:  op_b = rs2_v;
        endcase
    end

    always_comb begin
        if (!ctrl.rs1to32) begin
            a_ext = op_a;
        end else if (ctrl.alu_op == ALU_SRA) begin
            a_ext = {{(`DX_XLEN-32){op_a[31]}}, op_a[31:0]};
        end else begin
            a_ext = {{(`DX_XLEN-32){1'b0}}, op_a[31:0]}; // srlw shifts in zeros
        end
    end

    assign shamt = ctrl.rs1to32 ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    res = a_ext - op_b;
            ALU_SLL:    res = a_ext << shamt;
            ALU_SLT:    res = {{(`DX_XLEN-1){1'b0}}, $signed(a_ext) < $signed(op_b)};
            ALU_SLTU:   res = {{(`DX_XLEN-1){1'b0}}, a_ext < op_b};
            ALU_XOR:    res = a_ext ^ op_b;
            ALU_SRL:    res = a_ext >> shamt;
            ALU_SRA:    res = $signed(a_ext) >>> shamt;
            ALU_OR:     res = a_ext | op_b;
            ALU_AND:    res = a_ext & op_b;
            ALU_PASS_B: res = op_b;
            default:    res = a_ext + op_b;
        endcase
    end

    assign alu_result_o = ctrl.rs1to32 ? {{(`DX_XLEN-32){res[31]}}, res[31:0]} : res;

    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rs1_v == rs2_v);
            3'b001:  taken = (rs1_v != rs2_v);
            3'b100:  taken = $signed(rs1_v) < $signed(rs2_v);
            3'b101:  taken = $signed(rs1_v) >= $signed(rs2_v);
            3'b110:  taken = rs1_v < rs2_v;
            3'b111:  taken = rs1_v >= rs2_v;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = (ctrl.branch && taken) || ctrl.jal || ctrl.jalr;
    assign redirect_pc_o = ctrl.jalr ? ((rs1_v + ex_payload_i.imm) & ~`DX_XLEN'd1)
                                     : (ex_payload_i.pc + ex_payload_i.imm);

    assign rd_addr_o    = ex_payload_i.rd;
    assign rd_we_o      = ctrl.wb_en;
    assign mem_read_o   = ctrl.mem_read;
    assign mem_write_o  = ctrl.mem_write;
    assign mem_mask_o   = ctrl.mem_mask;
    assign load_sext_o  = ctrl.load_sext;
    assign store_data_o = rs2_v;

endmodule

//--- source/id_ex_reg.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module id_ex_reg (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                hold_i,
    dx_decode_if.stage          dec,
    input  logic [`DX_XLEN-1:0] pc_i,
    input  logic [`DX_XLEN-1:0] rs1_data_i,
    input  logic [`DX_XLEN-1:0] rs2_data_i,
    output dx_pkg::dx_payload_t ex_payload_o
);
    import dx_pkg::*;

    localparam dx_payload_t NOP_PAYLOAD = '0; // all controls cleared

    dx_payload_t next_payload;

    always_comb begin
        next_payload.ctrl     = dec.decoded_ctrl;
        next_payload.imm      = dec.imm;
        next_payload.pc       = pc_i;
        next_payload.rs1_data = rs1_data_i;
        next_payload.rs2_data = rs2_data_i;
        next_payload.rs1      = dec.rs1;
        next_payload.rs2      = dec.rs2;
        next_payload.rd       = dec.rd;
    end

    // flush beats hold
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_payload_o <= NOP_PAYLOAD;
        end else if (!hold_i) begin
            ex_payload_o <= next_payload;
        end
    end

    // priority above would hide a flush that arrives during a memory stall
    a_flush_hold_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(flush_i && hold_i))
        else $error("flush and hold both asserted");

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    dx_decode_if.hazard         dec,
    input  dx_pkg::dx_payload_t ex_payload_i,
    input  logic                redirect_i,
    input  logic                mem_stall_i,
    output logic                flush_o,
    output logic                hold_o,
    output logic                stall_o
);
    import dx_pkg::*;

    logic                  load_use;
    logic                  rs1_hit;
    logic                  rs2_hit;
    logic [`DX_REG_AW-1:0] ex_rd;

    assign ex_rd   = ex_payload_i.rd;
    assign rs1_hit = dec.uses_rs1 && (dec.rs1 == ex_rd);
    assign rs2_hit = dec.uses_rs2 && (dec.rs2 == ex_rd);

    // load in ex feeding the instruction in decode
    assign load_use = ex_payload_i.ctrl.mem_read && (ex_rd != '0) && (rs1_hit || rs2_hit);

    assign hold_o  = mem_stall_i;
    assign flush_o = !mem_stall_i && (load_use || redirect_i); // mem stall masks flush
    assign stall_o = mem_stall_i || load_use;

    // the bubble inserted by a load-use flush must clear the hazard
    a_single_load_use: assert property (@(posedge clk) disable iff (!rst_n_i)
        (load_use && !mem_stall_i) |=>
            (mem_stall_i || !(load_use && (ex_rd == $past(ex_rd)))))
        else $error("repeated load-use stall on x%0d", ex_rd);

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

module rv_decoder (
    input  logic [31:0]  instr_i,
    dx_decode_if.decoder dec
);
    import dx_pkg::*;

    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_OP32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;

    logic                    known;
    logic [31:0]             instr;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    alt;      // instr[30], sub and sra
    logic                    wr;
    logic [`DX_REG_AW-1:0]   rd_field;
    logic [`DX_XLEN-1:0]     imm_i;
    logic [`DX_XLEN-1:0]     imm_s;
    logic [`DX_XLEN-1:0]     imm_b;
    logic [`DX_XLEN-1:0]     imm_u;
    logic [`DX_XLEN-1:0]     imm_j;
    dx_ctrl_t                ctrl;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt_b,
                                        input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt_b && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_b ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic logic [`DX_MASK_W-1:0] size_mask(input logic [1:0] sz);
        logic [`DX_MASK_W-1:0] m;
        case (sz)
            2'b00:   m = 'h01;
            2'b01:   m = 'h03;
            2'b10:   m = 'h0f;
            default: m = 'hff;
        endcase
        return m;
    endfunction

    always_comb begin
        case (instr_i[6:0])
            OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP_IMM32, OPC_STORE, OPC_OP,
            OPC_LUI, OPC_OP32, OPC_BRANCH, OPC_JALR, OPC_JAL: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign instr    = known ? instr_i : `DX_NOP_INSTR; // unknown decodes as nop
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign alt      = instr[30];
    assign rd_field = instr[11:7];

    assign imm_i = {{(`DX_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`DX_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`DX_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(`DX_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`DX_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        ctrl         = '0;
        ctrl.funct3  = funct3;
        dec.imm      = '0;
        dec.uses_rs1 = 1'b0;
        dec.uses_rs2 = 1'b0;
        wr           = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP32: begin
                ctrl.alu_op  = alu_sel(funct3, alt, 1'b1);
                ctrl.rs1to32 = (opcode == OPC_OP32);
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                wr           = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM32: begin
                ctrl.alu_op  = alu_sel(funct3, alt, 1'b0);
                ctrl.sel_b   = OPB_IMM;
                ctrl.rs1to32 = (opcode == OPC_OP_IMM32);
                dec.imm      = imm_i;
                dec.uses_rs1 = 1'b1;
                wr           = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.sel_b     = OPB_IMM;
                ctrl.mem_read  = 1'b1;
                ctrl.mem_mask  = size_mask(funct3[1:0]);
                ctrl.load_sext = ~funct3[2];
                dec.imm        = imm_i;
                dec.uses_rs1   = 1'b1;
                wr             = 1'b1;
            end
            OPC_STORE: begin
                ctrl.sel_b     = OPB_IMM;
                ctrl.mem_write = 1'b1;
                ctrl.mem_mask  = size_mask(funct3[1:0]);
                dec.imm        = imm_s;
                dec.uses_rs1   = 1'b1;
                dec.uses_rs2   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch  = 1'b1;
                dec.imm      = imm_b;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.sel_a   = OPA_PC;   // link pc+4
                ctrl.sel_b   = OPB_FOUR;
                ctrl.jal     = (opcode == OPC_JAL);
                ctrl.jalr    = (opcode == OPC_JALR);
                dec.imm      = (opcode == OPC_JAL) ? imm_j : imm_i;
                dec.uses_rs1 = (opcode == OPC_JALR);
                wr           = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.sel_a  = OPA_ZERO;
                ctrl.sel_b  = OPB_IMM;
                dec.imm     = imm_u;
                wr          = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.sel_a = OPA_PC;
                ctrl.sel_b = OPB_IMM;
                dec.imm    = imm_u;
                wr         = 1'b1;
            end
            default: ;
        endcase
        ctrl.wb_en = wr && (rd_field != '0); // x0 writes dropped
    end

    assign dec.decoded_ctrl = ctrl;
    assign dec.rd           = ctrl.wb_en ? rd_field : '0;
    assign dec.rs1          = instr[19:15];
    assign dec.rs2          = instr[24:20];

endmodule

//--- source/dx_decode_if.sv
`timescale 1ns/100ps
`include "dx_settings.svh"

interface dx_decode_if;
    import dx_pkg::*;

    dx_ctrl_t                decoded_ctrl;
    logic [`DX_XLEN-1:0]     imm;
    logic [`DX_REG_AW-1:0]   rs1;
    logic [`DX_REG_AW-1:0]   rs2;
    logic [`DX_REG_AW-1:0]   rd;     // zero when nothing is written back
    logic                    uses_rs1;
    logic                    uses_rs2;

    modport decoder (
        output decoded_ctrl, imm, rs1, rs2, rd, uses_rs1, uses_rs2
    );

    modport stage (
        input decoded_ctrl, imm, rs1, rs2, rd
    );

    modport hazard (
        input rs1, rs2, uses_rs1, uses_rs2
    );

endinterface

//--- source/dx_pkg.sv
`include "dx_settings.svh"

package dx_pkg;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10 // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_PC   = 2'd1,
        OPA_ZERO = 2'd2
    } opa_sel_e;

    typedef enum logic [1:0] {
        OPB_RS2  = 2'd0,
        OPB_IMM  = 2'd1,
        OPB_FOUR = 2'd2 // link value for jumps
    } opb_sel_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        opa_sel_e                sel_a;
        opb_sel_e                sel_b;
        logic                    rs1to32;   // w forms, sext of low word
        logic                    wb_en;
        logic                    mem_read;
        logic                    mem_write;
        logic [`DX_MASK_W-1:0]   mem_mask;
        logic                    load_sext;
        logic                    branch;
        logic                    jal;
        logic                    jalr;
        logic [2:0]              funct3;    // branch or access kind
    } dx_ctrl_t;

    typedef struct packed {
        dx_ctrl_t                ctrl;
        logic [`DX_XLEN-1:0]     imm;
        logic [`DX_XLEN-1:0]     pc;
        logic [`DX_XLEN-1:0]     rs1_data;
        logic [`DX_XLEN-1:0]     rs2_data;
        logic [`DX_REG_AW-1:0]   rs1;
        logic [`DX_REG_AW-1:0]   rs2;
        logic [`DX_REG_AW-1:0]   rd;
    } dx_payload_t;

endpackage

//--- source/dx_settings.svh
`ifndef DX_SETTINGS_SVH
`define DX_SETTINGS_SVH

// data and pc width
`define DX_XLEN 64

// register address width
`define DX_REG_AW 5

// byte mask width, one bit per byte lane
`define DX_MASK_W (`DX_XLEN / 8)

// addi x0, x0, 0
`define DX_NOP_INSTR 32'h0000_0013

`endif
